//--- common/decoded_if.sv
`timescale 1ns/1ps

interface decoded_if;
	import rv_core_pkg::*;

	// forward, one decoded instruction
	logic valid;
	op_class_t op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic [2:0] funct3;
	logic alt;
	word_t imm;
	pc_t pc;

	// back from execute
	logic ready;
	pc_t next_pc;
	logic next_pc_valid;

	modport producer (
		output valid, op, rd, rs1, rs2, funct3, alt, imm, pc,
		input ready, next_pc, next_pc_valid
	);

	modport consumer (
		input valid, op, rd, rs1, rs2, funct3, alt, imm, pc,
		output ready, next_pc, next_pc_valid
	);

endinterface

//--- common/rv_core_pkg.sv
package rv_core_pkg;

	// ------------------------------------------------
	// widths
	// ------------------------------------------------
	localparam int xlen_w = 32;
	// word address, 256 words per memory
	localparam int pc_w = 8;
	localparam int reg_idx_w = 5;

	typedef logic [xlen_w-1:0] word_t;
	typedef logic [pc_w-1:0] pc_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// what execute has to do with an instruction
	// halt never leaves fetch
	typedef enum logic [2:0] {
		op_alu_r,
		op_alu_i,
		op_branch,
		op_jal,
		op_load,
		op_store,
		op_halt
	} op_class_t;

	// ------------------------------------------------
	// opcodes
	// ------------------------------------------------
	localparam logic [6:0] opc_r = 7'b0110011;
	localparam logic [6:0] opc_i = 7'b0010011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;

	// alu funct3, sub and sra picked by funct7 bit 5
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// branch funct3
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// apb map: bit 8 picks data memory, 7..0 word address
	localparam int apb_aw = 9;
	localparam int apb_dmem_bit = 8;

endpackage

//--- core/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input logic clk,
	input logic rst,
	decoded_if.consumer dec,
	output rv_core_pkg::reg_idx_t rf_rs1,
	output rv_core_pkg::reg_idx_t rf_rs2,
	input rv_core_pkg::word_t rf_rs1_data,
	input rv_core_pkg::word_t rf_rs2_data,
	output logic rf_wr_en,
	output rv_core_pkg::reg_idx_t rf_wr_idx,
	output rv_core_pkg::word_t rf_wr_data,
	output rv_core_pkg::pc_t dmem_addr,
	output rv_core_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input rv_core_pkg::word_t dmem_rdata
);
	import rv_core_pkg::*;

	typedef enum logic [2:0] {
		ex_idle,
		ex_oper,
		ex_exec,
		ex_mem,
		ex_load
	} ex_state_t;

	ex_state_t state;

	// latched instruction
	op_class_t op;
	reg_idx_t rd;
	logic [2:0] funct3;
	logic alt;
	word_t imm;
	pc_t pc;
	word_t op_a;
	word_t op_b;

	word_t alu_b;
	word_t alu_y;
	word_t sra_y;
	word_t mem_sum;
	logic taken;
	pc_t pc_plus1;
	pc_t pc_target;
	pc_t next_pc_c;

	assign dec.ready = (state == ex_idle);

	// ------------------------------------------------
	// alu
	// ------------------------------------------------
	// rs2 for r-type, immediate otherwise
	assign alu_b = (op == op_alu_r) ? op_b : imm;
	assign sra_y = $signed(op_a) >>> alu_b[4:0];

	always_comb
	begin
		case (funct3)
			f3_add: alu_y = (op == op_alu_r && alt) ? op_a - alu_b : op_a + alu_b;
			f3_sll: alu_y = op_a << alu_b[4:0];
			f3_slt: alu_y = {{(xlen_w-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			f3_sltu: alu_y = {{(xlen_w-1){1'b0}}, op_a < alu_b};
			f3_xor: alu_y = op_a ^ alu_b;
			f3_srl: alu_y = alt ? sra_y : op_a >> alu_b[4:0];
			f3_or: alu_y = op_a | alu_b;
			default: alu_y = op_a & alu_b;
		endcase
	end

	// branch compare on register values
	always_comb
	begin
		case (funct3)
			f3_beq: taken = (op_a == op_b);
			f3_bne: taken = (op_a != op_b);
			f3_blt: taken = ($signed(op_a) < $signed(op_b));
			f3_bge: taken = ($signed(op_a) >= $signed(op_b));
			f3_bltu: taken = (op_a < op_b);
			f3_bgeu: taken = (op_a >= op_b);
			default: taken = 1'b0;
		endcase
	end

	// word offsets, wrap at memory size
	assign pc_plus1 = pc + pc_t'(1);
	assign pc_target = pc + imm[pc_w-1:0];
	assign mem_sum = op_a + imm;

	always_comb
	begin
		case (op)
			op_branch: next_pc_c = taken ? pc_target : pc_plus1;
			op_jal: next_pc_c = pc_target;
			default: next_pc_c = pc_plus1;
		endcase
	end

	// ------------------------------------------------
	// sequencing, pulses last one cycle
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= ex_idle;
			rf_wr_en <= 1'b0;
			dmem_we <= 1'b0;
			dec.next_pc_valid <= 1'b0;
		end
		else
		begin
			rf_wr_en <= 1'b0;
			dmem_we <= 1'b0;
			dec.next_pc_valid <= 1'b0;
			case (state)
				ex_idle:
					if (dec.valid)
						state <= ex_oper;
				ex_oper:
					state <= ex_exec;
				ex_exec:
				begin
					case (op)
						// address goes out, wait for read data
						op_load:
							state <= ex_mem;
						op_store:
						begin
							dmem_we <= 1'b1;
							dec.next_pc_valid <= 1'b1;
							state <= ex_idle;
						end
						op_branch:
						begin
							dec.next_pc_valid <= 1'b1;
							state <= ex_idle;
						end
						// alu and jal write rd
						default:
						begin
							rf_wr_en <= 1'b1;
							dec.next_pc_valid <= 1'b1;
							state <= ex_idle;
						end
					endcase
				end
				ex_mem:
					state <= ex_load;
				default:
				begin
					rf_wr_en <= 1'b1;
					dec.next_pc_valid <= 1'b1;
					state <= ex_idle;
				end
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			ex_idle:
				if (dec.valid)
				begin
					op <= dec.op;
					rd <= dec.rd;
					funct3 <= dec.funct3;
					alt <= dec.alt;
					imm <= dec.imm;
					pc <= dec.pc;
					rf_rs1 <= dec.rs1;
					rf_rs2 <= dec.rs2;
				end
			// register file read settles here
			ex_oper:
			begin
				op_a <= rf_rs1_data;
				op_b <= rf_rs2_data;
			end
			ex_exec:
			begin
				rf_wr_idx <= rd;
				// jal links the next word address
				rf_wr_data <= (op == op_jal) ? {{(xlen_w-pc_w){1'b0}}, pc_plus1} : alu_y;
				dmem_addr <= mem_sum[pc_w-1:0];
				dmem_wdata <= op_b;
				dec.next_pc <= next_pc_c;
			end
			ex_load:
				rf_wr_data <= dmem_rdata;
			default:
				rf_wr_idx <= rd;
		endcase
	end

endmodule

//--- core/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode (
	input logic clk,
	input logic rst,
	input logic start,
	output logic done,
	output logic running,
	output rv_core_pkg::pc_t imem_addr,
	input rv_core_pkg::word_t imem_rdata,
	decoded_if.producer dec
);
	import rv_core_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_addr,
		s_read,
		s_issue,
		s_wait,
		s_halt
	} fd_state_t;

	fd_state_t state;
	pc_t pc;

	// decode of the word coming out of memory
	logic [6:0] opcode;
	logic [2:0] funct3_c;
	op_class_t op_c;
	word_t imm_c;
	logic alt_c;
	word_t b_imm;
	word_t j_imm;

	assign imem_addr = pc;
	// pc only moves while nothing is offered
	assign dec.pc = pc;

	assign opcode = imem_rdata[6:0];
	assign funct3_c = imem_rdata[14:12];

	// ------------------------------------------------
	// immediate generation
	// ------------------------------------------------
	// byte offsets as encoded, turned into words below
	assign b_imm = {{20{imem_rdata[31]}}, imem_rdata[7], imem_rdata[30:25],
		imem_rdata[11:8], 1'b0};
	assign j_imm = {{12{imem_rdata[31]}}, imem_rdata[19:12], imem_rdata[20],
		imem_rdata[30:21], 1'b0};

	always_comb
	begin
		// all-zero word has opcode 0, so it lands in default
		op_c = op_halt;
		imm_c = '0;
		alt_c = 1'b0;
		case (opcode)
			opc_r:
			begin
				op_c = op_alu_r;
				alt_c = imem_rdata[30];
			end
			opc_i:
			begin
				op_c = op_alu_i;
				// shamt in rs2 slot, funct7 bit 5 picks srai
				if (funct3_c == f3_sll || funct3_c == f3_srl)
				begin
					imm_c = {{(xlen_w-5){1'b0}}, imem_rdata[24:20]};
					alt_c = imem_rdata[30];
				end
				else
					imm_c = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
			end
			opc_branch:
			begin
				op_c = op_branch;
				// pc counts words
				imm_c = {{2{b_imm[31]}}, b_imm[31:2]};
			end
			opc_jal:
			begin
				op_c = op_jal;
				imm_c = {{2{j_imm[31]}}, j_imm[31:2]};
			end
			opc_load:
			begin
				op_c = op_load;
				imm_c = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
			end
			opc_store:
			begin
				op_c = op_store;
				imm_c = {{20{imem_rdata[31]}}, imem_rdata[31:25], imem_rdata[11:7]};
			end
			default:
				op_c = op_halt;
		endcase
	end

	// ------------------------------------------------
	// fetch sequencing, one instruction in flight
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			pc <= '0;
			running <= 1'b0;
			done <= 1'b0;
			dec.valid <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
					if (start)
					begin
						pc <= '0;
						running <= 1'b1;
						state <= s_addr;
					end
				// memory registers the word
				s_addr:
					state <= s_read;
				s_read:
					if (op_c == op_halt)
					begin
						done <= 1'b1;
						running <= 1'b0;
						state <= s_halt;
					end
					else
					begin
						dec.valid <= 1'b1;
						state <= s_issue;
					end
				// hold valid until taken
				s_issue:
					if (dec.ready)
					begin
						dec.valid <= 1'b0;
						state <= s_wait;
					end
				s_wait:
					if (dec.next_pc_valid)
					begin
						pc <= dec.next_pc;
						state <= s_addr;
					end
				// halted until reset
				default:
					state <= s_halt;
			endcase
		end
	end

	// decoded fields, captured with the word
	always_ff @(posedge clk)
	begin
		if (state == s_read)
		begin
			dec.op <= op_c;
			dec.rd <= imem_rdata[11:7];
			dec.rs1 <= imem_rdata[19:15];
			dec.rs2 <= imem_rdata[24:20];
			dec.funct3 <= funct3_c;
			dec.alt <= alt_c;
			dec.imm <= imm_c;
		end
	end

endmodule

//--- core/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,
	input rv_core_pkg::reg_idx_t rs1,
	input rv_core_pkg::reg_idx_t rs2,
	output rv_core_pkg::word_t rs1_data,
	output rv_core_pkg::word_t rs2_data,
	input logic wr_en,
	input rv_core_pkg::reg_idx_t wr_idx,
	input rv_core_pkg::word_t wr_data
);
	import rv_core_pkg::*;

	localparam int n_regs = 1 << reg_idx_w;

	word_t regs [n_regs];

	// combinational reads, x0 reads zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	// ------------------------------------------------
	// write port, lands at the next edge
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < n_regs; i++)
			begin
				regs[i] <= '0;
			end
		end
		// writes to x0 dropped
		else if (wr_en && wr_idx != '0)
		begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

//--- list.f
common/rv_core_pkg.sv
common/decoded_if.sv
src/word_mem.sv
src/apb_host_port.sv
core/fetch_decode.sv
core/reg_file.sv
core/execute_unit.sv
src/rv_core_top.sv
testbench/tb_rv_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_rv_core -f list.f -o tb_rv_core \
	&& ./obj_dir/tb_rv_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- src/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port (
	input logic clk,
	input logic rst,
	input logic running,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [rv_core_pkg::apb_aw-1:0] paddr,
	input rv_core_pkg::word_t pwdata,
	output rv_core_pkg::word_t prdata,
	output logic pready,
	output rv_core_pkg::pc_t host_addr,
	output rv_core_pkg::word_t host_wdata,
	output logic host_imem_we,
	output logic host_dmem_we,
	input rv_core_pkg::word_t imem_rdata,
	input rv_core_pkg::word_t dmem_rdata
);
	import rv_core_pkg::*;

	logic access;
	logic dmem_sel;

	// access phase of a transfer
	assign access = psel & penable;
	assign dmem_sel = paddr[apb_dmem_bit];

	// address already out in setup phase
	assign host_addr = paddr[pc_w-1:0];
	assign host_wdata = pwdata;

	// write once, on the completing cycle
	assign host_imem_we = access & pwrite & pready & ~dmem_sel;
	assign host_dmem_we = access & pwrite & pready & dmem_sel;

	// memory output is settled by the time pready rises
	assign prdata = dmem_sel ? dmem_rdata : imem_rdata;

	// ------------------------------------------------
	// one wait cycle per access, none at all while running
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pready <= 1'b0;
		end
		else
		begin
			// drops again right after the completing cycle
			pready <= access & ~running & ~pready;
		end
	end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
	parameter int mem_depth = 1 << rv_core_pkg::pc_w
) (
	input logic clk,
	input logic rst,
	input logic start,
	output logic done,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [rv_core_pkg::apb_aw-1:0] paddr,
	input rv_core_pkg::word_t pwdata,
	output rv_core_pkg::word_t prdata,
	output logic pready
);
	import rv_core_pkg::*;

	decoded_if dec0 ();

	logic running;

	// core side
	pc_t core_imem_addr;
	pc_t core_dmem_addr;
	word_t core_dmem_wdata;
	logic core_dmem_we;

	// register file
	reg_idx_t rf_rs1;
	reg_idx_t rf_rs2;
	reg_idx_t rf_wr_idx;
	word_t rf_rs1_data;
	word_t rf_rs2_data;
	word_t rf_wr_data;
	logic rf_wr_en;

	// host side
	pc_t host_addr;
	word_t host_wdata;
	logic host_imem_we;
	logic host_dmem_we;

	// memory ports
	pc_t imem_addr;
	logic imem_we;
	word_t imem_rdata;
	pc_t dmem_addr;
	word_t dmem_wdata;
	logic dmem_we;
	word_t dmem_rdata;

	// ------------------------------------------------
	// memories belong to the core while it runs
	// ------------------------------------------------
	assign imem_addr = running ? core_imem_addr : host_addr;
	assign imem_we = ~running & host_imem_we;
	assign dmem_addr = running ? core_dmem_addr : host_addr;
	assign dmem_wdata = running ? core_dmem_wdata : host_wdata;
	assign dmem_we = running ? core_dmem_we : host_dmem_we;

	fetch_decode fetch_decode0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.done(done),
		.running(running),
		.imem_addr(core_imem_addr),
		.imem_rdata(imem_rdata),
		.dec(dec0.producer)
	);

	reg_file reg_file0 (
		.clk(clk),
		.rst(rst),
		.rs1(rf_rs1),
		.rs2(rf_rs2),
		.rs1_data(rf_rs1_data),
		.rs2_data(rf_rs2_data),
		.wr_en(rf_wr_en),
		.wr_idx(rf_wr_idx),
		.wr_data(rf_wr_data)
	);

	execute_unit execute_unit0 (
		.clk(clk),
		.rst(rst),
		.dec(dec0.consumer),
		.rf_rs1(rf_rs1),
		.rf_rs2(rf_rs2),
		.rf_rs1_data(rf_rs1_data),
		.rf_rs2_data(rf_rs2_data),
		.rf_wr_en(rf_wr_en),
		.rf_wr_idx(rf_wr_idx),
		.rf_wr_data(rf_wr_data),
		.dmem_addr(core_dmem_addr),
		.dmem_wdata(core_dmem_wdata),
		.dmem_we(core_dmem_we),
		.dmem_rdata(dmem_rdata)
	);

	apb_host_port apb_host_port0 (
		.clk(clk),
		.rst(rst),
		.running(running),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_imem_we(host_imem_we),
		.host_dmem_we(host_dmem_we),
		.imem_rdata(imem_rdata),
		.dmem_rdata(dmem_rdata)
	);

	// core never writes instruction memory
	word_mem #(
		.depth(mem_depth)
	) instr_mem0 (
		.clk(clk),
		.addr(imem_addr),
		.wdata(host_wdata),
		.we(imem_we),
		.rdata(imem_rdata)
	);

	word_mem #(
		.depth(mem_depth)
	) data_mem0 (
		.clk(clk),
		.addr(dmem_addr),
		.wdata(dmem_wdata),
		.we(dmem_we),
		.rdata(dmem_rdata)
	);

endmodule

//--- src/word_mem.sv
`timescale 1ns/1ps

module word_mem #(
	parameter int depth = 256
) (
	input logic clk,
	input rv_core_pkg::pc_t addr,
	input rv_core_pkg::word_t wdata,
	input logic we,
	output rv_core_pkg::word_t rdata
);
	import rv_core_pkg::*;

	word_t mem [depth];

	// ------------------------------------------------
	// single port, read data one cycle after addr
	// ------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
		end
		// read during write returns the old word
		rdata <= mem[addr];
	end

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
	import rv_core_pkg::*;

	// row kinds
	localparam int k_r = 0;
	localparam int k_i = 1;
	localparam int k_br = 2;
	localparam int k_jal = 3;
	localparam int k_x0 = 4;

	localparam int n_rows = 37;
	localparam int cycle_limit = n_rows * 200;
	localparam int pready_limit = 150;
	localparam int done_limit = 150;
	// data word 2 is cleared to this before each run
	localparam logic [31:0] fill_word = 32'h5a5a_0f0f;

	logic clk;
	logic rst;
	logic start;
	logic done;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_aw-1:0] paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;

	// test table
	int row_kind [n_rows];
	int row_f3 [n_rows];
	logic row_alt [n_rows];
	int row_imm [n_rows];
	word_t row_a [n_rows];
	word_t row_b [n_rows];
	word_t row_exp [n_rows];

	integer seed;
	int nrow;
	int cur_row;
	int cycles;
	int checks;
	int mismatches;
	int other_errors;
	logic busy;

	rv_core_top dut0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.done(done),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------
	// rv32i instruction encoders
	// ------------------------------------------------
	function automatic word_t alu_rr(input logic alt, input int src2, input int src1,
		input int f3, input int rd);
		return {1'b0, alt, 5'b00000, src2[4:0], src1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t alu_ri(input int imm, input int src1, input int f3,
		input int rd);
		return {imm[11:0], src1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic word_t load_word(input int rd, input int src1, input int off);
		return {off[11:0], src1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic word_t store_word(input int src2, input int src1, input int off);
		return {off[11:5], src2[4:0], src1[4:0], 3'b010, off[4:0], 7'b0100011};
	endfunction

	// offsets given in words and encoded in bytes
	function automatic word_t branch_word(input int f3, input int src1, input int src2,
		input int words);
		int off;
		off = words * 4;
		return {off[12], off[10:5], src2[4:0], src1[4:0], f3[2:0], off[4:1], off[11],
			7'b1100011};
	endfunction

	function automatic word_t jump_word(input int rd, input int words);
		int off;
		off = words * 4;
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	// ------------------------------------------------
	// expected values from the isa rules
	// ------------------------------------------------
	function automatic word_t alu_model(input int f3, input logic alt, input word_t x,
		input word_t y);
		word_t r;
		word_t sra_r;
		// arithmetic shift keeps the sign
		sra_r = $signed(x) >>> y[4:0];
		case (f3)
			0: r = alt ? x - y : x + y;
			1: r = x << y[4:0];
			2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3: r = (x < y) ? 32'd1 : 32'd0;
			4: r = x ^ y;
			5: r = alt ? sra_r : x >> y[4:0];
			6: r = x | y;
			default: r = x & y;
		endcase
		return r;
	endfunction

	// 2 when the target ran and 1 on fall through
	function automatic word_t branch_model(input int f3, input word_t x, input word_t y);
		logic taken;
		case (f3)
			0: taken = (x == y);
			1: taken = (x != y);
			4: taken = ($signed(x) < $signed(y));
			5: taken = ($signed(x) >= $signed(y));
			6: taken = (x < y);
			default: taken = (x >= y);
		endcase
		return taken ? 32'd2 : 32'd1;
	endfunction

	task automatic add_row(input int k, input int f3, input logic alt, input int imm,
		input word_t x, input word_t y, input logic rnd);
		word_t va;
		word_t vb;
		va = x;
		vb = y;
		if (rnd)
		begin
			va = $random(seed);
			vb = $random(seed);
		end
		row_kind[nrow] = k;
		row_f3[nrow] = f3;
		row_alt[nrow] = alt;
		row_imm[nrow] = imm;
		row_a[nrow] = va;
		row_b[nrow] = vb;
		case (k)
			k_r: row_exp[nrow] = alu_model(f3, alt, va, vb);
			k_i: row_exp[nrow] = alu_model(f3, alt, va, word_t'(imm));
			k_br: row_exp[nrow] = branch_model(f3, va, vb);
			// link of jal at word 2
			k_jal: row_exp[nrow] = 32'd3;
			default: row_exp[nrow] = 32'd0;
		endcase
		nrow++;
	endtask

	task automatic build_table();
		// r-type on random operands
		add_row(k_r, 0, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 0, 1'b1, 0, '0, '0, 1'b1);
		add_row(k_r, 7, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 6, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 4, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 1, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 5, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 5, 1'b1, 0, '0, '0, 1'b1);
		add_row(k_r, 2, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_r, 3, 1'b0, 0, '0, '0, 1'b1);
		// sra of a negative value and slt against sltu on -5 and 3
		add_row(k_r, 5, 1'b1, 0, 32'h8000_0f00, 32'd4, 1'b0);
		add_row(k_r, 2, 1'b0, 0, 32'hffff_fffb, 32'd3, 1'b0);
		add_row(k_r, 3, 1'b0, 0, 32'hffff_fffb, 32'd3, 1'b0);
		// i-type with negative immediates
		add_row(k_i, 0, 1'b0, -5, '0, '0, 1'b1);
		add_row(k_i, 7, 1'b0, -16, '0, '0, 1'b1);
		add_row(k_i, 6, 1'b0, -256, '0, '0, 1'b1);
		add_row(k_i, 4, 1'b0, -1, '0, '0, 1'b1);
		add_row(k_i, 2, 1'b0, -1, 32'hffff_fff6, '0, 1'b0);
		add_row(k_i, 2, 1'b0, -1, '0, '0, 1'b1);
		add_row(k_i, 3, 1'b0, -1, '0, '0, 1'b1);
		// shifts by immediate where srai carries funct7 in the field
		add_row(k_i, 1, 1'b0, 7, '0, '0, 1'b1);
		add_row(k_i, 5, 1'b0, 9, '0, '0, 1'b1);
		add_row(k_i, 5, 1'b1, 32'h404, 32'h8000_1230, '0, 1'b0);
		// branches taken and not taken
		add_row(k_br, 0, 1'b0, 0, 32'd7, 32'd7, 1'b0);
		add_row(k_br, 0, 1'b0, 0, 32'd7, 32'd8, 1'b0);
		add_row(k_br, 1, 1'b0, 0, 32'd7, 32'd8, 1'b0);
		add_row(k_br, 1, 1'b0, 0, 32'd5, 32'd5, 1'b0);
		add_row(k_br, 4, 1'b0, 0, 32'hffff_fffd, 32'd2, 1'b0);
		add_row(k_br, 4, 1'b0, 0, 32'd2, 32'hffff_fffd, 1'b0);
		add_row(k_br, 5, 1'b0, 0, 32'd2, 32'hffff_fffd, 1'b0);
		add_row(k_br, 5, 1'b0, 0, 32'hffff_fffd, 32'd2, 1'b0);
		add_row(k_br, 6, 1'b0, 0, 32'd2, 32'hffff_fffd, 1'b0);
		add_row(k_br, 6, 1'b0, 0, 32'hffff_fffd, 32'd2, 1'b0);
		add_row(k_br, 7, 1'b0, 0, 32'hffff_fffd, 32'd2, 1'b0);
		add_row(k_br, 7, 1'b0, 0, 32'd2, 32'hffff_fffd, 1'b0);
		add_row(k_jal, 0, 1'b0, 0, '0, '0, 1'b1);
		add_row(k_x0, 0, 1'b0, 0, '0, '0, 1'b1);
	endtask

	// ------------------------------------------------
	// apb host side
	// ------------------------------------------------
	task automatic bus_transfer(input logic wr, input logic [apb_aw-1:0] addr,
		input word_t wdata, output word_t rdata);
		int waited;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		waited = 0;
		rdata = '0;
		while (pready !== 1'b1 && waited < pready_limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (pready !== 1'b1)
		begin
			other_errors++;
			$display("timeout: pready never rose for APB access to address %h", addr);
		end
		else
			rdata = prdata;
		// completing edge passes before this
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [apb_aw-1:0] addr, input word_t data);
		word_t unused;
		bus_transfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [apb_aw-1:0] addr, output word_t data);
		bus_transfer(1'b0, addr, '0, data);
	endtask

	// ------------------------------------------------
	// per-row sequence
	// ------------------------------------------------
	task automatic reset_dut();
		@(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		checks++;
		if (done !== 1'b0 || pready !== 1'b0)
		begin
			other_errors++;
			$display("done or pready not low after reset on row %0d", cur_row);
		end
	endtask

	// two loads then the op under test then a store to word 2 and a halt
	task automatic load_program(input int i);
		word_t prog [$];
		prog.push_back(load_word(1, 0, 0));
		prog.push_back(load_word(2, 0, 1));
		case (row_kind[i])
			k_r: prog.push_back(alu_rr(row_alt[i], 2, 1, row_f3[i], 3));
			k_i: prog.push_back(alu_ri(row_imm[i], 1, row_f3[i], 3));
			k_br:
			begin
				// fall through sets 1 and jumps over the target
				prog.push_back(branch_word(row_f3[i], 1, 2, 3));
				prog.push_back(alu_ri(1, 0, 0, 3));
				prog.push_back(jump_word(0, 2));
				prog.push_back(alu_ri(2, 0, 0, 3));
			end
			k_jal:
			begin
				// x6 only changes if the skipped word runs
				prog.push_back(jump_word(5, 2));
				prog.push_back(alu_ri(7, 0, 0, 6));
				prog.push_back(alu_rr(1'b0, 6, 5, 0, 3));
			end
			default: prog.push_back(alu_rr(1'b0, 2, 1, 0, 0));
		endcase
		if (row_kind[i] == k_x0)
			prog.push_back(store_word(0, 0, 2));
		else
			prog.push_back(store_word(3, 0, 2));
		prog.push_back(32'h0000_0000);
		for (int j = 0; j < prog.size(); j++)
		begin
			apb_write({1'b0, j[7:0]}, prog[j]);
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		while (done !== 1'b1 && waited < done_limit)
		begin
			@(negedge clk);
			waited++;
		end
		checks++;
		if (done !== 1'b1)
		begin
			other_errors++;
			$display("timeout: done never rose on row %0d", cur_row);
		end
	endtask

	task automatic run_row(input int i);
		word_t got;
		// done from the previous run still held
		if (i > 0)
		begin
			checks++;
			if (done !== 1'b1)
			begin
				other_errors++;
				$display("done dropped before reset on row %0d", i);
			end
		end
		reset_dut();
		apb_write({1'b1, 8'd2}, fill_word);
		apb_write({1'b1, 8'd0}, row_a[i]);
		apb_write({1'b1, 8'd1}, row_b[i]);
		load_program(i);
		@(negedge clk);
		start = 1'b1;
		busy = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// read stalls until the core halts
		apb_read({1'b1, 8'd2}, got);
		wait_done();
		busy = 1'b0;
		checks++;
		if (got !== row_exp[i])
		begin
			mismatches++;
			$display("MISMATCH at %0t: row %0d kind %0d f3 %0d a %h b %h got %h expected %h",
				$time, i, row_kind[i], row_f3[i], row_a[i], row_b[i], got, row_exp[i]);
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d, mismatches %0d, other errors %0d",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	// no apb completion while the core runs
	always @(negedge clk)
	begin
		if (busy && done !== 1'b1 && pready === 1'b1)
		begin
			other_errors++;
			$display("APB access completed while the core was running on row %0d", cur_row);
		end
	end

	// ------------------------------------------------
	// run limit
	// ------------------------------------------------
	initial
	begin
		cycles = 0;
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		other_errors++;
		$display("timeout: run exceeded %0d cycles", cycle_limit);
		report_and_finish();
	end

	initial
	begin
		rst = 1'b0;
		start = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		busy = 1'b0;
		cur_row = 0;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		nrow = 0;
		seed = 32'h6ee8;
		build_table();
		if (nrow != n_rows)
		begin
			other_errors++;
			$display("test table holds %0d rows instead of %0d", nrow, n_rows);
		end
		for (int i = 0; i < n_rows; i++)
		begin
			cur_row = i;
			run_row(i);
		end
		// halted core keeps done up
		repeat (5) @(negedge clk);
		checks++;
		if (done !== 1'b1)
		begin
			other_errors++;
			$display("done dropped after the last run");
		end
		report_and_finish();
	end

endmodule
